// File: inst_decoder_settings.svh
`ifndef INST_DECODER_SETTINGS_SVH
`define INST_DECODER_SETTINGS_SVH

// Instruction word as fetched from memory
`define INST_WIDTH 16

// Eight general registers
`define REG_ADDR_WIDTH 3

// Widest offset field, BL uses all 13 low bits
`define OFFSET_WIDTH 13

// Byte literal of the MOVL family
`define LITERAL_WIDTH 8

// Opcode enum encoding
// 37 codes including op_illegal
`define OPCODE_WIDTH 6

`endif

// File: isa_pkg.sv
`include "inst_decoder_settings.svh"

package isa_pkg;

    // Raw instruction word
    typedef logic [`INST_WIDTH-1:0] inst_word_t;

    // Register index for src and dst
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Offset fields, zero-extended up to the BL width
    typedef logic [`OFFSET_WIDTH-1:0] offset_t;

    // Literal byte carried by MOVL, MOVLZ, MOVLS, MOVH
    typedef logic [`LITERAL_WIDTH-1:0] byte_lit_t;

    // One code per decoded instruction
    // Zero is reserved for anything that matches no pattern
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        op_illegal = '0,
        // Branches
        op_bl,
        op_beq,
        op_bne,
        op_bc,
        op_bnc,
        op_bn,
        op_bge,
        op_blt,
        op_bra,
        // Two-operand register operations
        op_add,
        op_addc,
        op_sub,
        op_subc,
        op_dadd,
        op_cmp,
        op_xor,
        op_and,
        op_or,
        op_bit,
        op_bic,
        op_bis,
        // Register moves
        op_mov,
        op_swap,
        // Single-operand operations
        op_sra,
        op_rrc,
        op_comp,
        op_swpb,
        op_sxt,
        // Memory accesses, register indirect
        op_ld,
        op_st,
        // Literal moves
        op_movl,
        op_movlz,
        op_movls,
        op_movh,
        // Memory accesses, relative to a register
        op_ldr,
        op_str
    } opcode_t;

endpackage

// File: decode_pkg.sv
package decode_pkg;

    // Operand fields of a decoded instruction
    // Fields the instruction does not define stay zero
    typedef struct packed {
        // Branch or relative memory offset
        isa_pkg::offset_t   off;
        // Register or constant source select
        logic               rc;
        // Word or byte operation
        logic               wb;
        isa_pkg::reg_addr_t src;
        isa_pkg::reg_addr_t dst;
        // Pre or post address update for LD/ST
        logic               prpo;
        logic               dec;
        logic               inc;
        // Literal byte for the MOVL family
        isa_pkg::byte_lit_t lit;
    } decoded_fields_t;

    // Output of one group decoder
    typedef struct packed {
        // Set only when the word belongs to this group
        logic               hit;
        isa_pkg::opcode_t   op;
        decoded_fields_t    fields;
    } group_result_t;

    // Registered decoder output
    typedef struct packed {
        isa_pkg::opcode_t   op;
        decoded_fields_t    fields;
    } decoded_inst_t;

endpackage

// File: branch_decoder.sv
`timescale 1ns/1ns
`include "inst_decoder_settings.svh"

module branch_decoder (
    input  isa_pkg::inst_word_t       inst,
    output decode_pkg::group_result_t result
);

    // BL covers 0x0000 to 0x1FFF
    localparam isa_pkg::inst_word_t mask_bl    = 16'hE000;
    localparam isa_pkg::inst_word_t pattern_bl = 16'h0000;

    // Eight branches at 0x2000..0x3C00, mask 0xFC00, step 0x0400
    // Together they fill the whole 0x2000 to 0x3FFF block
    localparam isa_pkg::inst_word_t mask_cond_block    = 16'hE000;
    localparam isa_pkg::inst_word_t pattern_cond_block = 16'h2000;

    // Short offset of the conditional branches and BRA
    localparam int cond_off_width = 10;

    always_comb begin
        result = '0;
        if ((inst & mask_bl) == pattern_bl) begin
            result.hit        = 1'b1;
            result.op         = isa_pkg::op_bl;
            // Full 13-bit offset
            result.fields.off = inst[`OFFSET_WIDTH-1:0];
        end else if ((inst & mask_cond_block) == pattern_cond_block) begin
            result.hit        = 1'b1;
            result.fields.off = isa_pkg::offset_t'(inst[cond_off_width-1:0]);
            // Bits 12:10 pick the condition
            case (inst[12:10])
                3'd0:    result.op = isa_pkg::op_beq;
                3'd1:    result.op = isa_pkg::op_bne;
                3'd2:    result.op = isa_pkg::op_bc;
                3'd3:    result.op = isa_pkg::op_bnc;
                3'd4:    result.op = isa_pkg::op_bn;
                3'd5:    result.op = isa_pkg::op_bge;
                3'd6:    result.op = isa_pkg::op_blt;
                // 3'd7, unconditional
                default: result.op = isa_pkg::op_bra;
            endcase
        end
    end

endmodule

// File: register_op_decoder.sv
`timescale 1ns/1ns
`include "inst_decoder_settings.svh"

module register_op_decoder (
    input  isa_pkg::inst_word_t       inst,
    output decode_pkg::group_result_t result
);

    // Two-operand ops at 0x4000..0x4B00, mask 0xFF00
    localparam isa_pkg::inst_word_t mask_two_op_block    = 16'hF000;
    localparam isa_pkg::inst_word_t pattern_two_op_block = 16'h4000;
    // Last two-operand code in bits 11:8 (BIS)
    localparam logic [3:0]          last_two_op          = 4'hB;

    // MOV and SWAP share 0x4C00, bit 7 tells them apart
    localparam isa_pkg::inst_word_t mask_mov     = 16'hFF80;
    localparam isa_pkg::inst_word_t pattern_mov  = 16'h4C00;
    localparam isa_pkg::inst_word_t pattern_swap = 16'h4C80;

    // Single-operand ops, mask 0xFFB8 at 0x4D00 + 8*k
    // Bit 6 is WB and not part of the match
    localparam isa_pkg::inst_word_t mask_single_block    = 16'hFF80;
    localparam isa_pkg::inst_word_t pattern_single_block = 16'h4D00;
    // k runs from SRA (0) to SXT (4)
    localparam logic [2:0]          last_single          = 3'd4;

    // Literal moves at 0x6000..0x7800, mask 0xF800
    localparam isa_pkg::inst_word_t mask_lit_block    = 16'hE000;
    localparam isa_pkg::inst_word_t pattern_lit_block = 16'h6000;

    // Operand bit positions
    localparam int rc_bit  = 7;
    localparam int wb_bit  = 6;
    localparam int dst_lsb = 0;
    localparam int src_lsb = `REG_ADDR_WIDTH;
    localparam int lit_lsb = `REG_ADDR_WIDTH;

    isa_pkg::reg_addr_t src_field;
    isa_pkg::reg_addr_t dst_field;
    isa_pkg::byte_lit_t lit_field;

    // Raw slices, used only by the groups that define them
    assign src_field = inst[src_lsb +: `REG_ADDR_WIDTH];
    assign dst_field = inst[dst_lsb +: `REG_ADDR_WIDTH];
    assign lit_field = inst[lit_lsb +: `LITERAL_WIDTH];

    always_comb begin
        result = '0;
        if ((inst & mask_two_op_block) == pattern_two_op_block
                && inst[11:8] <= last_two_op) begin
            result.hit        = 1'b1;
            result.fields.rc  = inst[rc_bit];
            result.fields.wb  = inst[wb_bit];
            result.fields.src = src_field;
            result.fields.dst = dst_field;
            case (inst[11:8])
                4'h0:    result.op = isa_pkg::op_add;
                4'h1:    result.op = isa_pkg::op_addc;
                4'h2:    result.op = isa_pkg::op_sub;
                4'h3:    result.op = isa_pkg::op_subc;
                4'h4:    result.op = isa_pkg::op_dadd;
                4'h5:    result.op = isa_pkg::op_cmp;
                4'h6:    result.op = isa_pkg::op_xor;
                4'h7:    result.op = isa_pkg::op_and;
                4'h8:    result.op = isa_pkg::op_or;
                // BIT sits at 0x4900
                4'h9:    result.op = isa_pkg::op_bit;
                4'hA:    result.op = isa_pkg::op_bic;
                // 4'hB, the range check keeps out anything higher
                default: result.op = isa_pkg::op_bis;
            endcase
        end else if ((inst & mask_mov) == pattern_mov) begin
            result.hit        = 1'b1;
            result.op         = isa_pkg::op_mov;
            result.fields.wb  = inst[wb_bit];
            result.fields.src = src_field;
            result.fields.dst = dst_field;
        end else if ((inst & mask_mov) == pattern_swap) begin
            // SWAP is always a word exchange
            result.hit        = 1'b1;
            result.op         = isa_pkg::op_swap;
            result.fields.src = src_field;
            result.fields.dst = dst_field;
        end else if ((inst & mask_single_block) == pattern_single_block
                && inst[5:3] <= last_single) begin
            result.hit        = 1'b1;
            result.fields.dst = dst_field;
            case (inst[5:3])
                // SRA at 0x4D00
                3'd0: begin
                    result.op        = isa_pkg::op_sra;
                    result.fields.wb = inst[wb_bit];
                end
                3'd1: begin
                    result.op        = isa_pkg::op_rrc;
                    result.fields.wb = inst[wb_bit];
                end
                3'd2: begin
                    result.op        = isa_pkg::op_comp;
                    result.fields.wb = inst[wb_bit];
                end
                // Byte swap and sign extend have no size bit
                3'd3:    result.op = isa_pkg::op_swpb;
                default: result.op = isa_pkg::op_sxt;
            endcase
        end else if ((inst & mask_lit_block) == pattern_lit_block) begin
            result.hit        = 1'b1;
            result.fields.lit = lit_field;
            result.fields.dst = dst_field;
            case (inst[12:11])
                2'd0:    result.op = isa_pkg::op_movl;
                2'd1:    result.op = isa_pkg::op_movlz;
                2'd2:    result.op = isa_pkg::op_movls;
                default: result.op = isa_pkg::op_movh;
            endcase
        end
    end

endmodule

// File: load_store_decoder.sv
`timescale 1ns/1ns
`include "inst_decoder_settings.svh"

module load_store_decoder (
    input  isa_pkg::inst_word_t       inst,
    output decode_pkg::group_result_t result
);

    // Register-indirect LD and ST
    localparam isa_pkg::inst_word_t mask_ld_st = 16'hFC00;
    localparam isa_pkg::inst_word_t pattern_ld = 16'h5800;
    localparam isa_pkg::inst_word_t pattern_st = 16'h5C00;

    // Register-relative LDR and STR, top two bits only
    localparam isa_pkg::inst_word_t mask_rel    = 16'hC000;
    localparam isa_pkg::inst_word_t pattern_ldr = 16'h8000;
    localparam isa_pkg::inst_word_t pattern_str = 16'hC000;

    logic hit_ld;
    logic hit_st;
    logic hit_ldr;
    logic hit_str;

    assign hit_ld  = (inst & mask_ld_st) == pattern_ld;
    assign hit_st  = (inst & mask_ld_st) == pattern_st;
    assign hit_ldr = (inst & mask_rel) == pattern_ldr;
    assign hit_str = (inst & mask_rel) == pattern_str;

    always_comb begin
        result = '0;
        if (hit_ld || hit_st) begin
            result.hit         = 1'b1;
            result.op          = hit_ld ? isa_pkg::op_ld : isa_pkg::op_st;
            // Address register update controls
            result.fields.prpo = inst[9];
            result.fields.dec  = inst[8];
            result.fields.inc  = inst[7];
        end else if (hit_ldr || hit_str) begin
            result.hit        = 1'b1;
            result.op         = hit_ldr ? isa_pkg::op_ldr : isa_pkg::op_str;
            // 7-bit offset, zero-extended
            result.fields.off = isa_pkg::offset_t'(inst[13:7]);
        end

        // All four carry size, source and destination in the same place
        if (result.hit) begin
            result.fields.wb  = inst[6];
            result.fields.src = inst[2*`REG_ADDR_WIDTH-1:`REG_ADDR_WIDTH];
            result.fields.dst = inst[`REG_ADDR_WIDTH-1:0];
        end
    end

endmodule

// File: inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
    input  logic                      clk,
    input  logic                      reset,
    input  isa_pkg::inst_word_t       inst,
    input  logic                      inst_valid,
    output decode_pkg::decoded_inst_t dec,
    output logic                      dec_valid
);

    decode_pkg::group_result_t branch_result;
    decode_pkg::group_result_t register_op_result;
    decode_pkg::group_result_t load_store_result;

    // Merged result ahead of the output register
    decode_pkg::decoded_inst_t dec_next;

    // Branch group covers 0x0000 to 0x3FFF
    branch_decoder branch_decoder_inst (
        .inst   (inst),
        .result (branch_result)
    );

    // ALU ops, register moves and literal moves
    register_op_decoder register_op_decoder_inst (
        .inst   (inst),
        .result (register_op_result)
    );

    // LD, ST, LDR, STR
    load_store_decoder load_store_decoder_inst (
        .inst   (inst),
        .result (load_store_result)
    );

    // First hit wins in the order branch, register op, load/store
    // No hit gives op_illegal with all fields zero
    always_comb begin
        dec_next.op     = isa_pkg::op_illegal;
        dec_next.fields = '0;
        if (branch_result.hit) begin
            dec_next.op     = branch_result.op;
            dec_next.fields = branch_result.fields;
        end else if (register_op_result.hit) begin
            dec_next.op     = register_op_result.op;
            dec_next.fields = register_op_result.fields;
        end else if (load_store_result.hit) begin
            dec_next.op     = load_store_result.op;
            dec_next.fields = load_store_result.fields;
        end
    end

    // One-cycle valid pulse per accepted word
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= inst_valid;
        end
    end

    // Output payload holds between valid words
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            dec <= dec_next;
        end
    end

endmodule

// File: tb_inst_decoder.sv
`timescale 1ns/1ns

module tb_inst_decoder;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 4;
    localparam int random_count = 200;
    // Idle cycle after every 16th table word
    localparam int gap_every    = 16;

    // One table row holds an instruction word and the decode it must give
    typedef struct packed {
        isa_pkg::inst_word_t       inst;
        decode_pkg::decoded_inst_t exp;
    } table_entry_t;

    logic                      clk = 1'b0;
    logic                      reset;
    isa_pkg::inst_word_t       inst;
    logic                      inst_valid;
    decode_pkg::decoded_inst_t dec;
    logic                      dec_valid;

    table_entry_t stim_table[$];
    logic         table_ready = 1'b0;
    integer       seed = 75;

    // Word driven last cycle and checked this cycle
    logic                      pend_valid;
    decode_pkg::decoded_inst_t pend_exp;
    string                     pend_label;
    // Last output seen with dec_valid high
    logic                      have_last;
    decode_pkg::decoded_inst_t last_dec;

    // Opcode lists in pattern order
    // Index k stands for base + k * step
    isa_pkg::opcode_t branch_ops [8] = '{
        isa_pkg::op_beq, isa_pkg::op_bne, isa_pkg::op_bc, isa_pkg::op_bnc,
        isa_pkg::op_bn, isa_pkg::op_bge, isa_pkg::op_blt, isa_pkg::op_bra
    };
    isa_pkg::opcode_t two_ops [12] = '{
        isa_pkg::op_add, isa_pkg::op_addc, isa_pkg::op_sub, isa_pkg::op_subc,
        isa_pkg::op_dadd, isa_pkg::op_cmp, isa_pkg::op_xor, isa_pkg::op_and,
        isa_pkg::op_or, isa_pkg::op_bit, isa_pkg::op_bic, isa_pkg::op_bis
    };
    isa_pkg::opcode_t single_ops [5] = '{
        isa_pkg::op_sra, isa_pkg::op_rrc, isa_pkg::op_comp, isa_pkg::op_swpb, isa_pkg::op_sxt
    };
    isa_pkg::opcode_t literal_ops [4] = '{
        isa_pkg::op_movl, isa_pkg::op_movlz, isa_pkg::op_movls, isa_pkg::op_movh
    };

    inst_decoder inst_decoder_inst (
        .clk        (clk),
        .reset      (reset),
        .inst       (inst),
        .inst_valid (inst_valid),
        .dec        (dec),
        .dec_valid  (dec_valid)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    function automatic decode_pkg::decoded_fields_t make_fields(
        input isa_pkg::offset_t off, input logic rc, input logic wb,
        input isa_pkg::reg_addr_t src, input isa_pkg::reg_addr_t dst,
        input logic prpo, input logic dec_flag, input logic inc,
        input isa_pkg::byte_lit_t lit);
        decode_pkg::decoded_fields_t f;
        f.off  = off;
        f.rc   = rc;
        f.wb   = wb;
        f.src  = src;
        f.dst  = dst;
        f.prpo = prpo;
        f.dec  = dec_flag;
        f.inc  = inc;
        f.lit  = lit;
        return f;
    endfunction

    task automatic add_entry(input isa_pkg::inst_word_t word, input isa_pkg::opcode_t op,
                             input decode_pkg::decoded_fields_t fields);
        table_entry_t e;
        e.inst       = word;
        e.exp.op     = op;
        e.exp.fields = fields;
        stim_table.push_back(e);
    endtask

    // Reference decode straight from the masks and patterns
    // Groups tried in priority order branch, register op, load/store
    function automatic decode_pkg::decoded_inst_t model_decode(input isa_pkg::inst_word_t w);
        decode_pkg::decoded_inst_t d;
        int k;
        d    = '0;
        d.op = isa_pkg::op_illegal;
        if ((w & 16'hE000) == 16'h0000) begin
            d.op         = isa_pkg::op_bl;
            d.fields.off = w[12:0];
            return d;
        end
        for (k = 0; k < 8; k++) begin
            if ((w & 16'hFC00) == 16'h2000 + 16'h0400 * k) begin
                d.op         = branch_ops[k];
                d.fields.off = isa_pkg::offset_t'(w[9:0]);
                return d;
            end
        end
        for (k = 0; k < 12; k++) begin
            if ((w & 16'hFF00) == 16'h4000 + 16'h0100 * k) begin
                d.op         = two_ops[k];
                d.fields.rc  = w[7];
                d.fields.wb  = w[6];
                d.fields.src = w[5:3];
                d.fields.dst = w[2:0];
                return d;
            end
        end
        if ((w & 16'hFF80) == 16'h4C00) begin
            d.op         = isa_pkg::op_mov;
            d.fields.wb  = w[6];
            d.fields.src = w[5:3];
            d.fields.dst = w[2:0];
            return d;
        end
        if ((w & 16'hFF80) == 16'h4C80) begin
            d.op         = isa_pkg::op_swap;
            d.fields.src = w[5:3];
            d.fields.dst = w[2:0];
            return d;
        end
        for (k = 0; k < 5; k++) begin
            if ((w & 16'hFFB8) == 16'h4D00 + 16'h0008 * k) begin
                d.op         = single_ops[k];
                d.fields.dst = w[2:0];
                // Only SRA, RRC, COMP have a size bit
                if (k < 3) begin
                    d.fields.wb = w[6];
                end
                return d;
            end
        end
        for (k = 0; k < 4; k++) begin
            if ((w & 16'hF800) == 16'h6000 + 16'h0800 * k) begin
                d.op         = literal_ops[k];
                d.fields.lit = w[10:3];
                d.fields.dst = w[2:0];
                return d;
            end
        end
        if ((w & 16'hFC00) == 16'h5800 || (w & 16'hFC00) == 16'h5C00) begin
            d.op          = ((w & 16'hFC00) == 16'h5800) ? isa_pkg::op_ld : isa_pkg::op_st;
            d.fields.prpo = w[9];
            d.fields.dec  = w[8];
            d.fields.inc  = w[7];
            d.fields.wb   = w[6];
            d.fields.src  = w[5:3];
            d.fields.dst  = w[2:0];
            return d;
        end
        if ((w & 16'hC000) == 16'h8000 || (w & 16'hC000) == 16'hC000) begin
            d.op         = ((w & 16'hC000) == 16'h8000) ? isa_pkg::op_ldr : isa_pkg::op_str;
            d.fields.off = isa_pkg::offset_t'(w[13:7]);
            d.fields.wb  = w[6];
            d.fields.src = w[5:3];
            d.fields.dst = w[2:0];
        end
        return d;
    endfunction

    // make_fields column order is off rc wb src dst prpo dec inc lit
    task automatic build_table();
        // Branches with BL at its full 13-bit offset
        add_entry(16'h1ABC, isa_pkg::op_bl,    make_fields(13'h1ABC, 0, 0, 0, 0, 0, 0, 0, 8'h00));
        add_entry(16'h0000, isa_pkg::op_bl,    make_fields(13'h0000, 0, 0, 0, 0, 0, 0, 0, 8'h00));
        add_entry(16'h2155, isa_pkg::op_beq,   make_fields(13'h0155, 0, 0, 0, 0, 0, 0, 0, 8'h00));
        add_entry(16'h27FF, isa_pkg::op_bne,   make_fields(13'h03FF, 0, 0, 0, 0, 0, 0, 0, 8'h00));
        add_entry(16'h2801, isa_pkg::op_bc,    make_fields(13'h0001, 0, 0, 0, 0, 0, 0, 0, 8'h00));
        add_entry(16'h2E00, isa_pkg::op_bnc,   make_fields(13'h0200, 0, 0, 0, 0, 0, 0, 0, 8'h00));
        add_entry(16'h30AA, isa_pkg::op_bn,    make_fields(13'h00AA, 0, 0, 0, 0, 0, 0, 0, 8'h00));
        add_entry(16'h3523, isa_pkg::op_bge,   make_fields(13'h0123, 0, 0, 0, 0, 0, 0, 0, 8'h00));
        add_entry(16'h3AF0, isa_pkg::op_blt,   make_fields(13'h02F0, 0, 0, 0, 0, 0, 0, 0, 8'h00));
        add_entry(16'h3FC3, isa_pkg::op_bra,   make_fields(13'h03C3, 0, 0, 0, 0, 0, 0, 0, 8'h00));
        // Two-operand ops with BIT at 0x4900
        add_entry(16'h400A, isa_pkg::op_add,   make_fields(13'h0000, 0, 0, 1, 2, 0, 0, 0, 8'h00));
        add_entry(16'h418F, isa_pkg::op_addc,  make_fields(13'h0000, 1, 0, 1, 7, 0, 0, 0, 8'h00));
        add_entry(16'h4253, isa_pkg::op_sub,   make_fields(13'h0000, 0, 1, 2, 3, 0, 0, 0, 8'h00));
        add_entry(16'h43FF, isa_pkg::op_subc,  make_fields(13'h0000, 1, 1, 7, 7, 0, 0, 0, 8'h00));
        add_entry(16'h4421, isa_pkg::op_dadd,  make_fields(13'h0000, 0, 0, 4, 1, 0, 0, 0, 8'h00));
        add_entry(16'h45C4, isa_pkg::op_cmp,   make_fields(13'h0000, 1, 1, 0, 4, 0, 0, 0, 8'h00));
        add_entry(16'h4635, isa_pkg::op_xor,   make_fields(13'h0000, 0, 0, 6, 5, 0, 0, 0, 8'h00));
        add_entry(16'h4746, isa_pkg::op_and,   make_fields(13'h0000, 0, 1, 0, 6, 0, 0, 0, 8'h00));
        add_entry(16'h489C, isa_pkg::op_or,    make_fields(13'h0000, 1, 0, 3, 4, 0, 0, 0, 8'h00));
        add_entry(16'h492D, isa_pkg::op_bit,   make_fields(13'h0000, 0, 0, 5, 5, 0, 0, 0, 8'h00));
        add_entry(16'h4A78, isa_pkg::op_bic,   make_fields(13'h0000, 0, 1, 7, 0, 0, 0, 0, 8'h00));
        add_entry(16'h4BE2, isa_pkg::op_bis,   make_fields(13'h0000, 1, 1, 4, 2, 0, 0, 0, 8'h00));
        // MOV and SWAP
        // SWAP has no size bit
        add_entry(16'h4C5E, isa_pkg::op_mov,   make_fields(13'h0000, 0, 1, 3, 6, 0, 0, 0, 8'h00));
        add_entry(16'h4C07, isa_pkg::op_mov,   make_fields(13'h0000, 0, 0, 0, 7, 0, 0, 0, 8'h00));
        add_entry(16'h4CF1, isa_pkg::op_swap,  make_fields(13'h0000, 0, 0, 6, 1, 0, 0, 0, 8'h00));
        // Single-operand ops starting with SRA at 0x4D00
        add_entry(16'h4D43, isa_pkg::op_sra,   make_fields(13'h0000, 0, 1, 0, 3, 0, 0, 0, 8'h00));
        add_entry(16'h4D0D, isa_pkg::op_rrc,   make_fields(13'h0000, 0, 0, 0, 5, 0, 0, 0, 8'h00));
        add_entry(16'h4D57, isa_pkg::op_comp,  make_fields(13'h0000, 0, 1, 0, 7, 0, 0, 0, 8'h00));
        add_entry(16'h4D5A, isa_pkg::op_swpb,  make_fields(13'h0000, 0, 0, 0, 2, 0, 0, 0, 8'h00));
        add_entry(16'h4D21, isa_pkg::op_sxt,   make_fields(13'h0000, 0, 0, 0, 1, 0, 0, 0, 8'h00));
        // Literal moves
        add_entry(16'h652C, isa_pkg::op_movl,  make_fields(13'h0000, 0, 0, 0, 4, 0, 0, 0, 8'hA5));
        add_entry(16'h6FF8, isa_pkg::op_movlz, make_fields(13'h0000, 0, 0, 0, 0, 0, 0, 0, 8'hFF));
        add_entry(16'h7406, isa_pkg::op_movls, make_fields(13'h0000, 0, 0, 0, 6, 0, 0, 0, 8'h80));
        add_entry(16'h79E1, isa_pkg::op_movh,  make_fields(13'h0000, 0, 0, 0, 1, 0, 0, 0, 8'h3C));
        // Memory accesses
        add_entry(16'h5AD5, isa_pkg::op_ld,    make_fields(13'h0000, 0, 1, 2, 5, 1, 0, 1, 8'h00));
        add_entry(16'h5D38, isa_pkg::op_st,    make_fields(13'h0000, 0, 0, 7, 0, 0, 1, 0, 8'h00));
        add_entry(16'hAADC, isa_pkg::op_ldr,   make_fields(13'h0055, 0, 1, 3, 4, 0, 0, 0, 8'h00));
        add_entry(16'hFF8E, isa_pkg::op_str,   make_fields(13'h007F, 0, 0, 1, 6, 0, 0, 0, 8'h00));
        // Status and control words followed by unused holes
        add_entry(16'h4D80, isa_pkg::op_illegal, '0);
        add_entry(16'h4D90, isa_pkg::op_illegal, '0);
        add_entry(16'h4DA0, isa_pkg::op_illegal, '0);
        add_entry(16'h4DC0, isa_pkg::op_illegal, '0);
        add_entry(16'h5000, isa_pkg::op_illegal, '0);
        add_entry(16'h5400, isa_pkg::op_illegal, '0);
        add_entry(16'h4D28, isa_pkg::op_illegal, '0);
        add_entry(16'h4E00, isa_pkg::op_illegal, '0);
        add_entry(16'h4FFF, isa_pkg::op_illegal, '0);
    endtask

    // Drive one word and check the word driven one cycle earlier
    task automatic apply_cycle(input isa_pkg::inst_word_t word, input logic valid,
                               input decode_pkg::decoded_inst_t exp, input string label);
        @(posedge clk);
        inst       <= word;
        inst_valid <= valid;
        @(negedge clk);
        check_value(dec_valid, pend_valid, {"dec_valid after ", pend_label});
        if (pend_valid) begin
            check_value(dec.op, pend_exp.op, {"opcode of ", pend_label});
            check_value(dec.fields, pend_exp.fields, {"fields of ", pend_label});
            last_dec  = pend_exp;
            have_last = 1'b1;
        end else if (have_last) begin
            // Payload must hold while no word is valid
            check_value(dec, last_dec, {"held output after ", pend_label});
        end
        pend_valid = valid;
        pend_exp   = exp;
        pend_label = label;
    endtask

    initial begin
        int                  i;
        isa_pkg::inst_word_t w;
        logic                v;
        reset      = 1'b1;
        inst       = '0;
        inst_valid = 1'b0;
        pend_valid = 1'b0;
        pend_exp   = '0;
        pend_label = "reset";
        have_last  = 1'b0;
        last_dec   = '0;
        build_table();
        table_ready = 1'b1;

        repeat (reset_cycles - 1) @(posedge clk);
        @(negedge clk);
        check_value(dec_valid, 1'b0, "dec_valid during reset");
        @(posedge clk);
        reset <= 1'b0;

        // Nothing valid yet
        repeat (3) apply_cycle('0, 1'b0, '0, "idle after reset");

        // Back to back with an occasional gap
        for (i = 0; i < stim_table.size(); i++) begin
            apply_cycle(stim_table[i].inst, 1'b1, stim_table[i].exp,
                        $sformatf("table entry %0d (0x%04h)", i, stim_table[i].inst));
            if (i % gap_every == gap_every - 1) begin
                apply_cycle('0, 1'b0, '0, "gap in stream");
            end
        end

        // Random words with about one cycle in four idle
        for (i = 0; i < random_count; i++) begin
            w = isa_pkg::inst_word_t'($random(seed));
            v = (($random(seed) & 3) != 0);
            apply_cycle(w, v, model_decode(w), $sformatf("random word %0d (0x%04h)", i, w));
        end

        // Drain the last word
        repeat (2) apply_cycle('0, 1'b0, '0, "flush");

        $display("*** TEST PASSED ***");
        $finish;
    end

    // Watchdog sized from table length and random count
    initial begin
        time limit;
        wait (table_ready);
        limit = (stim_table.size() + random_count + 20) * clk_period;
        #(limit);
        $display("Timeout: the decoder test did not finish within %0t ns", limit);
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped by the watchdog");
    end

endmodule

// File: build.f
+incdir+.
isa_pkg.sv
decode_pkg.sv
branch_decoder.sv
register_op_decoder.sv
load_store_decoder.sv
inst_decoder.sv
tb_inst_decoder.sv

// File: Bender.yml
package:
  name: inst_decoder

export_include_dirs:
  - .

sources:
  - isa_pkg.sv
  - decode_pkg.sv
  - branch_decoder.sv
  - register_op_decoder.sv
  - load_store_decoder.sv
  - inst_decoder.sv
  - target: test
    files:
      - tb_inst_decoder.sv
